// File: hw/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// address and fetch word
`define ICACHE_ADDR_W 64
`define ICACHE_DATA_W 64

// two ways of 64 sets
`define ICACHE_WAYS 2
`define ICACHE_SETS 64

// index is addr[10:5], word select addr[4:3]
`define ICACHE_INDEX_W 6
`define ICACHE_OFFSET_W 5
`define ICACHE_WORDS 4

// tag is addr[63:11]
`define ICACHE_TAG_W 53

`endif

// File: hw/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

	typedef enum logic [1:0] {
		ST_IDLE     = 2'd0,
		ST_LOOKUP   = 2'd1,
		ST_REFILL   = 2'd2,
		ST_RELOOKUP = 2'd3
	} ctrl_state_e;

	typedef enum logic [1:0] {
		RF_IDLE    = 2'd0,
		RF_REQ     = 2'd1, // req high, beats arriving
		RF_RELEASE = 2'd2, // req low, waiting for ack to drop
		RF_DONE    = 2'd3
	} refill_state_e;

	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0] index_t;
	typedef logic [$clog2(`ICACHE_WORDS)-1:0] word_sel_t;

endpackage

// File: hw/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tag_array (
	input  logic                clk,
	input  logic                rst_n,
	input  icache_pkg::index_t  lookup_index,
	input  icache_pkg::tag_t    lookup_tag,
	input  logic                tag_wr_en,
	input  logic                fill_way,
	input  logic                touch_en,
	input  logic                touch_way,
	input  logic                flush,
	output logic                hit,
	output logic                hit_way,
	output logic                victim_way
);

	logic [`ICACHE_SETS-1:0] valid [`ICACHE_WAYS];
	icache_pkg::tag_t tags [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] mru; // most recently used way per set
	logic [`ICACHE_WAYS-1:0] way_hit;

	// both ways compared in parallel
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_hit[w] = valid[w][lookup_index] && (tags[w][lookup_index] == lookup_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// invalid way 0, then invalid way 1, then the lru way
	always_comb begin
		if (!valid[0][lookup_index])
			victim_way = 1'b0;
		else if (!valid[1][lookup_index])
			victim_way = 1'b1;
		else
			victim_way = ~mru[lookup_index];
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid[w] <= '0;
			end
			mru <= '0;
		end else if (tag_wr_en) begin
			valid[fill_way][lookup_index] <= 1'b1;
			mru[lookup_index] <= fill_way; // new line becomes mru
		end else if (touch_en) begin
			mru[lookup_index] <= touch_way;
		end
	end

	// tag store written on refill
	always_ff @(posedge clk) begin
		if (tag_wr_en)
			tags[fill_way][lookup_index] <= lookup_tag;
	end

endmodule

// File: hw/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_data_array (
	input  logic                         clk,
	input  logic                         wr_en,
	input  icache_pkg::index_t           wr_index,
	input  logic                         wr_way,
	input  icache_pkg::word_sel_t        wr_word,
	input  logic [`ICACHE_DATA_W-1:0]    wr_data,
	input  icache_pkg::index_t           rd_index,
	input  logic                         rd_way,
	input  icache_pkg::word_sel_t        rd_word,
	output logic [`ICACHE_DATA_W-1:0]    rd_data
);

	// way, set, word
	logic [`ICACHE_DATA_W-1:0] lines [`ICACHE_WAYS][`ICACHE_SETS][`ICACHE_WORDS];

	// one refill beat per cycle
	always_ff @(posedge clk) begin
		if (wr_en)
			lines[wr_way][wr_index][wr_word] <= wr_data;
	end

	assign rd_data = lines[rd_way][rd_index][rd_word]; // async word select

endmodule

// File: hw/icache_refill.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_refill (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         refill_start,
	input  icache_pkg::index_t           line_index,
	input  icache_pkg::tag_t             line_tag,
	input  logic                         mem_ack,
	input  logic                         mem_rvalid,
	input  logic [`ICACHE_DATA_W-1:0]    mem_rdata,
	output logic                         refill_done,
	output logic                         mem_req,
	output logic [`ICACHE_ADDR_W-1:0]    mem_addr,
	output logic                         wr_en,
	output icache_pkg::word_sel_t        wr_word,
	output logic [`ICACHE_DATA_W-1:0]    wr_data
);

	icache_pkg::refill_state_e state;
	icache_pkg::word_sel_t beat_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= icache_pkg::RF_IDLE;
			mem_req <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				icache_pkg::RF_IDLE: begin
					if (refill_start) begin
						mem_req <= 1'b1;
						beat_cnt <= '0;
						state <= icache_pkg::RF_REQ;
					end
				end
				icache_pkg::RF_REQ: begin
					if (mem_rvalid)
						beat_cnt <= beat_cnt + 1'b1;
					// ack comes with the last beat
					if (mem_ack) begin
						mem_req <= 1'b0;
						state <= icache_pkg::RF_RELEASE;
					end
				end
				icache_pkg::RF_RELEASE: begin
					if (!mem_ack)
						state <= icache_pkg::RF_DONE;
				end
				default: state <= icache_pkg::RF_IDLE;
			endcase
		end
	end

	// line address, held for the whole request
	always_ff @(posedge clk) begin
		if (state == icache_pkg::RF_IDLE && refill_start)
			mem_addr <= {line_tag, line_index, {`ICACHE_OFFSET_W{1'b0}}};
	end

	assign wr_en = (state == icache_pkg::RF_REQ) && mem_rvalid;
	assign wr_word = beat_cnt;
	assign wr_data = mem_rdata;
	assign refill_done = (state == icache_pkg::RF_DONE);

endmodule

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         cpu_req_valid,
	input  logic [`ICACHE_ADDR_W-1:0]    cpu_req_addr,
	input  logic                         fence_i,
	input  logic                         hit,
	input  logic                         hit_way,
	input  logic                         victim_way,
	input  logic                         refill_done,
	input  logic [`ICACHE_DATA_W-1:0]    rd_data,
	output logic                         cpu_ready,
	output logic [`ICACHE_DATA_W-1:0]    cpu_data,
	output icache_pkg::index_t           req_index,
	output icache_pkg::tag_t             req_tag,
	output icache_pkg::word_sel_t        req_word,
	output logic                         fill_way,
	output logic                         tag_wr_en,
	output logic                         touch_en,
	output logic                         touch_way,
	output logic                         flush,
	output logic                         refill_start
);

	localparam int WORD_LSB = $clog2(`ICACHE_DATA_W / 8);
	localparam int INDEX_LSB = `ICACHE_OFFSET_W;
	localparam int TAG_LSB = `ICACHE_OFFSET_W + `ICACHE_INDEX_W;

	icache_pkg::ctrl_state_e state, next_state;
	logic accept;
	logic in_lookup;

	assign accept = (state == icache_pkg::ST_IDLE) && cpu_req_valid;
	assign in_lookup = (state == icache_pkg::ST_LOOKUP) || (state == icache_pkg::ST_RELOOKUP);

	always_comb begin
		next_state = state;
		case (state)
			icache_pkg::ST_IDLE: begin
				if (cpu_req_valid)
					next_state = icache_pkg::ST_LOOKUP;
			end
			icache_pkg::ST_LOOKUP, icache_pkg::ST_RELOOKUP: begin
				if (hit)
					next_state = icache_pkg::ST_IDLE;
				else
					next_state = icache_pkg::ST_REFILL;
			end
			icache_pkg::ST_REFILL: begin
				if (refill_done)
					next_state = icache_pkg::ST_RELOOKUP;
			end
			default: next_state = icache_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= icache_pkg::ST_IDLE;
		else
			state <= next_state;
	end

	// request fields held until the response
	always_ff @(posedge clk) begin
		if (accept) begin
			req_index <= cpu_req_addr[TAG_LSB-1:INDEX_LSB];
			req_tag <= cpu_req_addr[`ICACHE_ADDR_W-1:TAG_LSB];
			req_word <= cpu_req_addr[INDEX_LSB-1:WORD_LSB];
		end
	end

	// victim fixed at miss time
	always_ff @(posedge clk) begin
		if (in_lookup && !hit)
			fill_way <= victim_way;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			cpu_ready <= 1'b0;
		else
			cpu_ready <= in_lookup && hit;
	end

	always_ff @(posedge clk) begin
		if (in_lookup && hit)
			cpu_data <= rd_data;
	end

	assign refill_start = in_lookup && !hit;
	assign tag_wr_en = (state == icache_pkg::ST_REFILL) && refill_done;
	assign touch_en = in_lookup && hit;
	assign touch_way = hit_way;
	assign flush = (state == icache_pkg::ST_IDLE) && fence_i; // only legal when idle

endmodule

// File: hw/icache_top.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         cpu_req_valid,
	input  logic [`ICACHE_ADDR_W-1:0]    cpu_req_addr,
	output logic                         cpu_ready,
	output logic [`ICACHE_DATA_W-1:0]    cpu_data,
	input  logic                         fence_i,
	output logic                         mem_req,
	output logic [`ICACHE_ADDR_W-1:0]    mem_addr,
	input  logic                         mem_ack,
	input  logic                         mem_rvalid,
	input  logic [`ICACHE_DATA_W-1:0]    mem_rdata
);

	icache_pkg::index_t req_index;
	icache_pkg::tag_t req_tag;
	icache_pkg::word_sel_t req_word;
	icache_pkg::word_sel_t wr_word;
	logic hit, hit_way, victim_way;
	logic fill_way, tag_wr_en, touch_en, touch_way, flush;
	logic refill_start, refill_done;
	logic wr_en;
	logic [`ICACHE_DATA_W-1:0] wr_data;
	logic [`ICACHE_DATA_W-1:0] rd_data;

	icache_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_addr  (cpu_req_addr),
		.fence_i       (fence_i),
		.hit           (hit),
		.hit_way       (hit_way),
		.victim_way    (victim_way),
		.refill_done   (refill_done),
		.rd_data       (rd_data),
		.cpu_ready     (cpu_ready),
		.cpu_data      (cpu_data),
		.req_index     (req_index),
		.req_tag       (req_tag),
		.req_word      (req_word),
		.fill_way      (fill_way),
		.tag_wr_en     (tag_wr_en),
		.touch_en      (touch_en),
		.touch_way     (touch_way),
		.flush         (flush),
		.refill_start  (refill_start)
	);

	icache_refill u_refill (
		.clk          (clk),
		.rst_n        (rst_n),
		.refill_start (refill_start),
		.line_index   (req_index),
		.line_tag     (req_tag),
		.mem_ack      (mem_ack),
		.mem_rvalid   (mem_rvalid),
		.mem_rdata    (mem_rdata),
		.refill_done  (refill_done),
		.mem_req      (mem_req),
		.mem_addr     (mem_addr),
		.wr_en        (wr_en),
		.wr_word      (wr_word),
		.wr_data      (wr_data)
	);

	icache_tag_array u_tag_array (
		.clk          (clk),
		.rst_n        (rst_n),
		.lookup_index (req_index),
		.lookup_tag   (req_tag),
		.tag_wr_en    (tag_wr_en),
		.fill_way     (fill_way),
		.touch_en     (touch_en),
		.touch_way    (touch_way),
		.flush        (flush),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way)
	);

	// refill writes go to the latched fill way
	icache_data_array u_data_array (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_index (req_index),
		.wr_way   (fill_way),
		.wr_word  (wr_word),
		.wr_data  (wr_data),
		.rd_index (req_index),
		.rd_way   (hit_way),
		.rd_word  (req_word),
		.rd_data  (rd_data)
	);

endmodule

// File: tests/icache_assert.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_assert (
	input logic                         clk,
	input logic                         rst_n,
	input logic                         cpu_ready,
	input logic                         mem_req,
	input logic                         mem_ack,
	input logic [`ICACHE_ADDR_W-1:0]    mem_addr
);

	int err_count = 0; // failed assertions so far

	ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |=> !cpu_ready)
	else begin
		$error("cpu_ready stayed high for two cycles");
		err_count++;
	end

	// req may only drop once ack was seen
	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(mem_req) |-> $past(mem_ack))
	else begin
		$error("mem_req fell without mem_ack");
		err_count++;
	end

	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && $past(mem_req) |-> $stable(mem_addr))
	else begin
		$error("mem_addr changed during a request");
		err_count++;
	end

endmodule

bind icache_top icache_assert u_icache_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.cpu_ready (cpu_ready),
	.mem_req   (mem_req),
	.mem_ack   (mem_ack),
	.mem_addr  (mem_addr)
);

// File: tests/icache_tb.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tb;

	localparam int CLK_PERIOD = 8;
	localparam int N_RAND = 200;
	localparam int N_REQ = N_RAND + 9; // random plus directed fetches
	localparam logic [63:0] MUL_K = 64'h9E37_79B9_7F4A_7C15;

	logic clk = 1'b0;
	logic rst_n;
	logic cpu_req_valid;
	logic [`ICACHE_ADDR_W-1:0] cpu_req_addr;
	logic cpu_ready;
	logic [`ICACHE_DATA_W-1:0] cpu_data;
	logic fence_i;
	logic mem_req;
	logic [`ICACHE_ADDR_W-1:0] mem_addr;
	logic mem_ack;
	logic mem_rvalid;
	logic [`ICACHE_DATA_W-1:0] mem_rdata;

	integer seed = 3224;
	icache_pkg::tag_t tag_pool [4];
	icache_pkg::index_t index_pool [4];
	logic m_valid [`ICACHE_WAYS][`ICACHE_SETS]; // reference model state
	icache_pkg::tag_t m_tag [`ICACHE_WAYS][`ICACHE_SETS];
	logic m_mru [`ICACHE_SETS];

	always #(CLK_PERIOD / 2) clk = ~clk;

	icache_top u_icache_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_addr  (cpu_req_addr),
		.cpu_ready     (cpu_ready),
		.cpu_data      (cpu_data),
		.fence_i       (fence_i),
		.mem_req       (mem_req),
		.mem_addr      (mem_addr),
		.mem_ack       (mem_ack),
		.mem_rvalid    (mem_rvalid),
		.mem_rdata     (mem_rdata)
	);

	function automatic logic [63:0] mem_word(input logic [63:0] addr);
		logic [63:0] w;
		w = addr >> 3;
		return (w * MUL_K) ^ (addr >> 11); // tag salt
	endfunction

	function automatic logic [63:0] make_addr(input icache_pkg::tag_t t,
			input icache_pkg::index_t i, input icache_pkg::word_sel_t w);
		return {t, i, w, 3'b000};
	endfunction

	function automatic void model_flush();
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			m_valid[0][s] = 1'b0;
			m_valid[1][s] = 1'b0;
			m_mru[s] = 1'b0;
		end
	endfunction

	// returns 1 for a predicted miss
	function automatic logic model_access(input logic [63:0] addr);
		icache_pkg::tag_t t;
		icache_pkg::index_t i;
		logic way;
		logic miss;
		t = addr[63:11];
		i = addr[10:5];
		miss = 1'b0;
		if (m_valid[0][i] && m_tag[0][i] == t) begin
			way = 1'b0;
		end else if (m_valid[1][i] && m_tag[1][i] == t) begin
			way = 1'b1;
		end else begin
			miss = 1'b1;
			if (!m_valid[0][i])
				way = 1'b0;
			else if (!m_valid[1][i])
				way = 1'b1;
			else
				way = ~m_mru[i]; // lru way
			m_valid[way][i] = 1'b1;
			m_tag[way][i] = t;
		end
		m_mru[i] = way;
		return miss;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			$display("Simulation failed");
			$fatal(1, "check mismatch");
		end
	endtask

	task automatic do_fetch(input string name, input logic [63:0] addr, output logic missed);
		logic exp_miss;
		logic saw_req;
		int cycles;
		exp_miss = model_access(addr);
		saw_req = 1'b0;
		cycles = 0;
		cpu_req_valid = 1'b1;
		cpu_req_addr = addr;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles == 1)
				cpu_req_valid = 1'b0; // accepted at the last edge
			if (mem_req && !saw_req) begin
				saw_req = 1'b1;
				check({name, " req cycle"}, 2, cycles);
				check({name, " mem_addr"}, {addr[63:5], 5'b0}, mem_addr);
			end
		end while (!cpu_ready);
		check({name, " miss"}, exp_miss, saw_req);
		check({name, " data"}, mem_word(addr), cpu_data);
		if (!exp_miss)
			check({name, " hit latency"}, 2, cycles);
		missed = saw_req;
	endtask

	task automatic pulse_fence();
		fence_i = 1'b1;
		@(posedge clk);
		#1;
		fence_i = 1'b0;
		model_flush();
	endtask

	// four beats with random gaps and ack on the last one
	task automatic serve_line();
		logic [63:0] line;
		int gap;
		line = mem_addr;
		for (int b = 0; b < `ICACHE_WORDS; b++) begin
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) begin
				mem_rvalid = 1'b0;
				@(posedge clk);
				#1;
			end
			mem_rvalid = 1'b1;
			mem_rdata = mem_word(line + b * 8);
			mem_ack = (b == `ICACHE_WORDS - 1);
			@(posedge clk);
			#1;
		end
		mem_rvalid = 1'b0;
		while (mem_req) begin
			@(posedge clk);
			#1;
		end
		mem_ack = 1'b0;
	endtask

	always begin
		@(posedge clk);
		#1;
		if (mem_req)
			serve_line();
	end

	always @(posedge clk) begin
		if (u_icache_top.u_icache_assert.err_count != 0) begin
			$display("a handshake assertion failed");
			$display("Simulation failed");
			$fatal(1, "assertion failure");
		end
	end

	initial begin
		#((N_REQ * 40 + 8) * CLK_PERIOD);
		$display("timeout: the fetches did not finish in time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic missed;
		logic [1:0] pick;
		icache_pkg::tag_t t;
		icache_pkg::index_t s;
		rst_n = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req_addr = '0;
		fence_i = 1'b0;
		mem_ack = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		tag_pool[0] = 53'h1;
		tag_pool[1] = 53'h2A5;
		tag_pool[2] = 53'h1F_FFFF_FFFF_FFFF;
		tag_pool[3] = 53'h0_1234_5678_9ABC;
		index_pool[0] = 6'd0;
		index_pool[1] = 6'd17;
		index_pool[2] = 6'd42;
		index_pool[3] = 6'd63;
		model_flush();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check("reset cpu_ready", 0, cpu_ready);
		check("reset mem_req", 0, mem_req);

		// three tags into one set
		s = index_pool[1];
		do_fetch("fill a", make_addr(tag_pool[0], s, 2'd0), missed);
		do_fetch("fill b", make_addr(tag_pool[1], s, 2'd1), missed);
		do_fetch("touch a", make_addr(tag_pool[0], s, 2'd2), missed);
		do_fetch("fill c", make_addr(tag_pool[2], s, 2'd3), missed);
		do_fetch("a kept", make_addr(tag_pool[0], s, 2'd1), missed);
		check("a kept", 0, missed);
		do_fetch("b evicted", make_addr(tag_pool[1], s, 2'd0), missed);
		check("b evicted", 1, missed);

		// everything refetched after a fence
		pulse_fence();
		do_fetch("fence a", make_addr(tag_pool[0], s, 2'd0), missed);
		check("fence a", 1, missed);
		do_fetch("fence b", make_addr(tag_pool[1], s, 2'd2), missed);
		check("fence b", 1, missed);
		do_fetch("refetch a", make_addr(tag_pool[0], s, 2'd3), missed);
		check("refetch a", 0, missed);

		for (int n = 0; n < N_RAND; n++) begin
			pick = 2'($random(seed));
			t = tag_pool[pick];
			pick = 2'($random(seed));
			s = index_pool[pick];
			if ($unsigned($random(seed)) % 32 == 0)
				pulse_fence();
			do_fetch("random", make_addr(t, s, icache_pkg::word_sel_t'($random(seed))), missed);
		end

		repeat (4) @(posedge clk);
		if (u_icache_top.u_icache_assert.err_count == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("a handshake assertion failed");
			$display("Simulation failed");
			$fatal(1, "assertion failure");
		end
	end

endmodule

// File: flist.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tests/icache_assert.sv
tests/icache_tb.sv
